//--- src/vec_pkg.sv
// Vector core shared definitions
package vec_pkg;

  // Element and scalar data width
  localparam int ELEN = 32;

  localparam int NUM_VREGS = 8;
  localparam int VREG_ADDR_W = 3;
  localparam int XREG_ADDR_W = 5;

  // Sized for up to 16 lanes
  localparam int VL_W = 5;

  typedef logic [ELEN-1:0] xdata_t;
  typedef logic [XREG_ADDR_W-1:0] xaddr_t;
  typedef logic [VREG_ADDR_W-1:0] vaddr_t;
  typedef logic [VL_W-1:0] vl_t;

  typedef enum logic [3:0] {
    OP_VSETVL  = 4'd0,
    OP_VMV_VX  = 4'd1,
    OP_VADD_VV = 4'd2,
    OP_VSUB_VV = 4'd3,
    OP_VAND_VV = 4'd4,
    OP_VXOR_VV = 4'd5,
    OP_VADD_VX = 4'd6,
    OP_VMV_XS  = 4'd7,
    OP_VREDSUM = 4'd8
  } vec_op_e;

  // Instruction as presented on a slot, scalar operand comes separately
  typedef struct packed {
    vec_op_e op;
    vaddr_t  vd;
    vaddr_t  vs1;
    vaddr_t  vs2;
    xaddr_t  rd;
  } vec_inst_t;

  // Queued command with operand value and vl frozen at acceptance
  typedef struct packed {
    vec_op_e op;
    vaddr_t  vd;
    vaddr_t  vs1;
    vaddr_t  vs2;
    xaddr_t  rd;
    xdata_t  scalar;
    vl_t     vl;
  } vec_cmd_t;

  typedef struct packed {
    vl_t vl;
  } config_state_t;

  // Ops that return a scalar through the async write-back port
  function automatic logic is_scalar_op(input vec_op_e op);
    return (op == OP_VMV_XS) || (op == OP_VREDSUM);
  endfunction

endpackage

//--- src/vec_cmd_queue.sv
// Multi-write command queue
`timescale 1ns/10ps

module vec_cmd_queue #(
  parameter type ElemT = logic [31:0],
  parameter int N = 4,
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                             clk,
  input  logic                             arst_n_i,
  input  logic [N-1:0]                     push_i,
  input  ElemT [N-1:0]                     data_i,
  input  logic                             pop_i,
  output ElemT                             head_o,
  output logic                             not_empty_o,
  output logic [$clog2(QUEUE_DEPTH+1)-1:0] free_count_o
);

  // Depth is a power of two so the pointers wrap on their own
  localparam int PTR_W = $clog2(QUEUE_DEPTH);
  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  ElemT mem [QUEUE_DEPTH];

  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] push_cnt;

  // Pushes arrive packed from slot 0 upward
  always_comb begin
    push_cnt = '0;
    for (int j = 0; j < N; j++) begin
      push_cnt = push_cnt + CNT_W'(push_i[j]);
    end
  end

  always_ff @(posedge clk) begin
    for (int j = 0; j < N; j++) begin
      if (push_i[j]) begin
        mem[wr_ptr + PTR_W'(j)] <= data_i[j];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr       <= '0;
      rd_ptr       <= '0;
      free_count_o <= CNT_W'(QUEUE_DEPTH);
    end else begin
      wr_ptr       <= wr_ptr + PTR_W'(push_cnt);
      rd_ptr       <= rd_ptr + PTR_W'(pop_i);
      // Same-edge push and pop both land here
      free_count_o <= free_count_o - push_cnt + CNT_W'(pop_i);
    end
  end

  assign head_o      = mem[rd_ptr];
  assign not_empty_o = (free_count_o != CNT_W'(QUEUE_DEPTH));

endmodule

//--- src/vec_frontend.sv
// Instruction front end
`timescale 1ns/10ps

module vec_frontend #(
  parameter int N = 4,
  parameter int NUM_LANES = 4,
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                              clk,
  input  logic                              arst_n_i,
  input  logic [N-1:0]                      inst_valid_i,
  input  vec_pkg::vec_inst_t [N-1:0]        inst_data_i,
  input  vec_pkg::xdata_t [N-1:0]           reg_read_data_i,
  input  logic [$clog2(QUEUE_DEPTH+1)-1:0]  free_count_i,
  output logic [N-1:0]                      inst_ready_o,
  output logic [N-1:0]                      reg_write_valid_o,
  output vec_pkg::xaddr_t [N-1:0]           reg_write_addr_o,
  output vec_pkg::xdata_t [N-1:0]           reg_write_data_o,
  output logic [N-1:0]                      push_o,
  output vec_pkg::vec_cmd_t [N-1:0]         cmd_o,
  output vec_pkg::config_state_t            config_state_o
);
  import vec_pkg::*;

  int          cap;
  int          used;
  logic        prev_ok;
  logic        is_cfg;
  vl_t         cur_vl;
  logic [N-1:0] cfg_hit;
  vl_t [N-1:0] cfg_vl;

  function automatic vl_t clamp_vl(input xdata_t avl);
    if (avl > xdata_t'(NUM_LANES)) begin
      return vl_t'(NUM_LANES);
    end
    return vl_t'(avl);
  endfunction

  always_comb begin
    // Queue-bound slots limited by free space, never more than N
    cap = (int'(free_count_i) > N) ? N : int'(free_count_i);
    used = 0;
    prev_ok = 1'b1;
    cur_vl = config_state_o.vl;
    inst_ready_o = '0;
    push_o = '0;
    cmd_o = '0;
    cfg_hit = '0;
    cfg_vl = '0;
    for (int i = 0; i < N; i++) begin
      is_cfg = (inst_data_i[i].op == OP_VSETVL);
      // In-order prefix, stop at the first slot that cannot go
      inst_ready_o[i] = prev_ok && inst_valid_i[i] && (is_cfg || used < cap);
      prev_ok = inst_ready_o[i];
      if (inst_ready_o[i]) begin
        if (is_cfg) begin
          cur_vl = clamp_vl(reg_read_data_i[i]);
          cfg_hit[i] = 1'b1;
          cfg_vl[i] = cur_vl;
        end else begin
          // Later slots see vl from any vsetvl ahead of them
          push_o[used] = 1'b1;
          cmd_o[used] = '{
            op:     inst_data_i[i].op,
            vd:     inst_data_i[i].vd,
            vs1:    inst_data_i[i].vs1,
            vs2:    inst_data_i[i].vs2,
            rd:     inst_data_i[i].rd,
            scalar: reg_read_data_i[i],
            vl:     cur_vl
          };
          used++;
        end
      end
    end
  end

  // Config write-back one cycle after acceptance
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      reg_write_valid_o <= '0;
      config_state_o    <= '0;
    end else begin
      reg_write_valid_o <= cfg_hit;
      config_state_o.vl <= cur_vl;
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < N; i++) begin
      if (cfg_hit[i]) begin
        reg_write_addr_o[i] <= inst_data_i[i].rd;
        reg_write_data_o[i] <= xdata_t'(cfg_vl[i]);
      end
    end
  end

endmodule

//--- src/vec_dispatch.sv
// Command dispatcher
`timescale 1ns/10ps

module vec_dispatch (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              not_empty_i,
  input  vec_pkg::vec_cmd_t head_i,
  input  logic              collect_busy_i,
  output logic              pop_o,
  output logic              issue_valid_o,
  output vec_pkg::vec_cmd_t issue_cmd_o,
  output logic              in_flight_o
);
  import vec_pkg::*;

  logic head_scalar;
  logic sc_issue;
  // Scalar command sitting in the lane output stage
  logic sc_lane_q;

  assign head_scalar = is_scalar_op(head_i.op);
  assign sc_issue    = issue_valid_o && is_scalar_op(issue_cmd_o.op);

  // Only one scalar result may be on its way to the collector
  assign pop_o = not_empty_i &&
                 !(head_scalar && (collect_busy_i || sc_issue || sc_lane_q));

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      issue_valid_o <= 1'b0;
      sc_lane_q     <= 1'b0;
    end else begin
      issue_valid_o <= pop_o;
      sc_lane_q     <= sc_issue;
    end
  end

  always_ff @(posedge clk) begin
    if (pop_o) begin
      issue_cmd_o <= head_i;
    end
  end

  // Element-wise work retires at the lane edge, scalar work at the handshake
  assign in_flight_o = issue_valid_o || sc_lane_q || collect_busy_i;

endmodule

//--- src/vec_lane.sv
// Vector element lane
`timescale 1ns/10ps

module vec_lane #(
  parameter int LANE_IDX = 0
) (
  input  logic              clk,
  input  logic              arst_n_i,
  input  logic              issue_valid_i,
  input  vec_pkg::vec_cmd_t issue_cmd_i,
  output logic              elem_valid_o,
  output vec_pkg::xdata_t   elem_data_o
);
  import vec_pkg::*;

  // This lane's slice of every vector register
  xdata_t vregs [NUM_VREGS];

  logic   active;
  logic   wr_en;
  xdata_t src1;
  xdata_t src2;
  xdata_t alu_res;
  xdata_t elem_next;

  assign active = vl_t'(LANE_IDX) < issue_cmd_i.vl;
  assign src1   = vregs[issue_cmd_i.vs1];
  assign src2   = vregs[issue_cmd_i.vs2];

  always_comb begin
    wr_en   = 1'b1;
    alu_res = src2;
    case (issue_cmd_i.op)
      OP_VMV_VX:  alu_res = issue_cmd_i.scalar;
      OP_VADD_VV: alu_res = src2 + src1;
      OP_VSUB_VV: alu_res = src2 - src1;
      OP_VAND_VV: alu_res = src2 & src1;
      OP_VXOR_VV: alu_res = src2 ^ src1;
      OP_VADD_VX: alu_res = src2 + issue_cmd_i.scalar;
      default:    wr_en = 1'b0;
    endcase
    // Tail elements stay undisturbed
    wr_en = wr_en && issue_valid_i && active;
  end

  always_comb begin
    elem_next = '0;
    if (issue_cmd_i.op == OP_VMV_XS && LANE_IDX == 0) begin
      elem_next = src2;
    end else if (issue_cmd_i.op == OP_VREDSUM && active) begin
      elem_next = src2;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      vregs[issue_cmd_i.vd] <= alu_res;
    end
    elem_data_o <= elem_next;
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      elem_valid_o <= 1'b0;
    end else begin
      elem_valid_o <= issue_valid_i && is_scalar_op(issue_cmd_i.op);
    end
  end

endmodule

//--- src/vec_result_collect.sv
// Scalar result collector
`timescale 1ns/10ps

module vec_result_collect #(
  parameter int NUM_LANES = 4
) (
  input  logic                            clk,
  input  logic                            arst_n_i,
  input  logic [NUM_LANES-1:0]            elem_valid_i,
  input  vec_pkg::xdata_t [NUM_LANES-1:0] elem_data_i,
  input  vec_pkg::xaddr_t                 rd_i,
  input  logic                            async_rd_ready_i,
  output logic                            busy_o,
  output logic                            async_rd_valid_o,
  output vec_pkg::xaddr_t                 async_rd_addr_o,
  output vec_pkg::xdata_t                 async_rd_data_o
);
  import vec_pkg::*;

  logic   arrive;
  xdata_t sum;
  // rd follows the command into the lane stage
  xaddr_t rd_q;

  assign arrive = |elem_valid_i;

  // Idle lanes present zero, so vmv.x.s reduces to lane 0
  always_comb begin
    sum = '0;
    for (int l = 0; l < NUM_LANES; l++) begin
      if (elem_valid_i[l]) begin
        sum = sum + elem_data_i[l];
      end
    end
  end

  always_ff @(posedge clk) begin
    rd_q <= rd_i;
    if (arrive) begin
      async_rd_addr_o <= rd_q;
      async_rd_data_o <= sum;
    end
  end

  // Held until the consumer takes it
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      async_rd_valid_o <= 1'b0;
    end else if (arrive) begin
      async_rd_valid_o <= 1'b1;
    end else if (async_rd_ready_i) begin
      async_rd_valid_o <= 1'b0;
    end
  end

  assign busy_o = async_rd_valid_o;

endmodule

//--- src/vec_core.sv
// Vector coprocessor core
`timescale 1ns/10ps

module vec_core #(
  parameter int N = 4,
  parameter int NUM_LANES = 4,
  parameter int QUEUE_DEPTH = 8
) (
  input  logic                          clk,
  input  logic                          arst_n_i,
  input  logic [N-1:0]                  inst_valid_i,
  input  vec_pkg::vec_inst_t [N-1:0]    inst_data_i,
  input  vec_pkg::xdata_t [N-1:0]       reg_read_data_i,
  output logic [N-1:0]                  inst_ready_o,
  output logic [N-1:0]                  reg_write_valid_o,
  output vec_pkg::xaddr_t [N-1:0]       reg_write_addr_o,
  output vec_pkg::xdata_t [N-1:0]       reg_write_data_o,
  output logic                          async_rd_valid_o,
  output vec_pkg::xaddr_t               async_rd_addr_o,
  output vec_pkg::xdata_t               async_rd_data_o,
  input  logic                          async_rd_ready_i,
  output vec_pkg::config_state_t        config_state_o,
  output logic                          idle_o
);
  import vec_pkg::*;

  localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

  logic [N-1:0]           push;
  vec_cmd_t [N-1:0]       cmd;
  logic [CNT_W-1:0]       free_count;
  logic                   queue_not_empty;
  vec_cmd_t               queue_head;
  logic                   pop;
  logic                   issue_valid;
  vec_cmd_t               issue_cmd;
  logic                   in_flight;
  logic [NUM_LANES-1:0]   elem_valid;
  xdata_t [NUM_LANES-1:0] elem_data;
  logic                   collect_busy;

  vec_frontend #(.N(N), .NUM_LANES(NUM_LANES), .QUEUE_DEPTH(QUEUE_DEPTH)) frontend_inst (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .inst_valid_i(inst_valid_i),
    .inst_data_i(inst_data_i),
    .reg_read_data_i(reg_read_data_i),
    .free_count_i(free_count),
    .inst_ready_o(inst_ready_o),
    .reg_write_valid_o(reg_write_valid_o),
    .reg_write_addr_o(reg_write_addr_o),
    .reg_write_data_o(reg_write_data_o),
    .push_o(push),
    .cmd_o(cmd),
    .config_state_o(config_state_o)
  );

  vec_cmd_queue #(.ElemT(vec_pkg::vec_cmd_t), .N(N), .QUEUE_DEPTH(QUEUE_DEPTH)) queue_inst (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .push_i(push),
    .data_i(cmd),
    .pop_i(pop),
    .head_o(queue_head),
    .not_empty_o(queue_not_empty),
    .free_count_o(free_count)
  );

  vec_dispatch dispatch_inst (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .not_empty_i(queue_not_empty),
    .head_i(queue_head),
    .collect_busy_i(collect_busy),
    .pop_o(pop),
    .issue_valid_o(issue_valid),
    .issue_cmd_o(issue_cmd),
    .in_flight_o(in_flight)
  );

  // One element slice per lane, all fed the same command
  for (genvar l = 0; l < NUM_LANES; l++) begin : g_lane
    vec_lane #(.LANE_IDX(l)) lane_inst (
      .clk(clk),
      .arst_n_i(arst_n_i),
      .issue_valid_i(issue_valid),
      .issue_cmd_i(issue_cmd),
      .elem_valid_o(elem_valid[l]),
      .elem_data_o(elem_data[l])
    );
  end

  vec_result_collect #(.NUM_LANES(NUM_LANES)) collect_inst (
    .clk(clk),
    .arst_n_i(arst_n_i),
    .elem_valid_i(elem_valid),
    .elem_data_i(elem_data),
    .rd_i(issue_cmd.rd),
    .async_rd_ready_i(async_rd_ready_i),
    .busy_o(collect_busy),
    .async_rd_valid_o(async_rd_valid_o),
    .async_rd_addr_o(async_rd_addr_o),
    .async_rd_data_o(async_rd_data_o)
  );

  assign idle_o = !(queue_not_empty || in_flight);

endmodule

//--- test/vec_ref_model.svh
// Vector core reference model
`ifndef VEC_REF_MODEL_SVH
`define VEC_REF_MODEL_SVH

// Shadow copy of every register, one element slice per lane
xdata_t ref_vregs [NUM_LANES][NUM_VREGS];
vl_t    ref_vl = '0;

// Applies one accepted instruction in program order
function automatic xdata_t ref_execute(input vec_inst_t ins, input xdata_t scalar);
  xdata_t a;
  xdata_t b;
  xdata_t acc;
  acc = '0;
  if (ins.op == OP_VSETVL) begin
    ref_vl = (scalar > xdata_t'(NUM_LANES)) ? vl_t'(NUM_LANES) : vl_t'(scalar);
    return xdata_t'(ref_vl);
  end
  for (int l = 0; l < NUM_LANES; l++) begin
    a = ref_vregs[l][ins.vs1];
    b = ref_vregs[l][ins.vs2];
    // Elements at or beyond vl are left alone and not summed
    if (l < ref_vl) begin
      acc = acc + b;
      case (ins.op)
        OP_VMV_VX:  ref_vregs[l][ins.vd] = scalar;
        OP_VADD_VV: ref_vregs[l][ins.vd] = b + a;
        OP_VSUB_VV: ref_vregs[l][ins.vd] = b - a;
        OP_VAND_VV: ref_vregs[l][ins.vd] = b & a;
        OP_VXOR_VV: ref_vregs[l][ins.vd] = b ^ a;
        OP_VADD_VX: ref_vregs[l][ins.vd] = b + scalar;
        default:    ;
      endcase
    end
  end
  // Element 0 regardless of vl
  if (ins.op == OP_VMV_XS) begin
    return ref_vregs[0][ins.vs2];
  end
  return acc;
endfunction

`endif

//--- test/vec_core_tb.sv
// Vector core testbench
`timescale 1ns/10ps

module vec_core_tb;
  import vec_pkg::*;

  localparam int N = 4;
  localparam int NUM_LANES = 4;
  localparam int QUEUE_DEPTH = 8;
  localparam int RUN_TIMEOUT = 2000;
  localparam int IDLE_TIMEOUT = 200;

  logic              clk = 1'b0;
  logic              arst_n_i;
  logic [N-1:0]      inst_valid_i;
  vec_inst_t [N-1:0] inst_data_i;
  xdata_t [N-1:0]    reg_read_data_i;
  logic [N-1:0]      inst_ready_o;
  logic [N-1:0]      reg_write_valid_o;
  xaddr_t [N-1:0]    reg_write_addr_o;
  xdata_t [N-1:0]    reg_write_data_o;
  logic              async_rd_valid_o;
  xaddr_t            async_rd_addr_o;
  xdata_t            async_rd_data_o;
  logic              async_rd_ready_i;
  config_state_t     config_state_o;
  logic              idle_o;

  // Program not yet accepted with its scalar operands
  vec_inst_t prog_inst [$];
  xdata_t    prog_scalar [$];
  // Scalar results in program order
  xaddr_t    exp_addr_q [$];
  xdata_t    exp_data_q [$];

  logic [N-1:0] wr_exp_mask;
  xaddr_t       wr_exp_addr [N];
  xdata_t       wr_exp_data [N];
  logic         held_valid;
  xaddr_t       held_addr;
  xdata_t       held_data;
  logic         rand_ready;
  logic         stall_seen;

  vec_op_e op_table [10] = '{OP_VSETVL, OP_VMV_VX, OP_VADD_VV, OP_VSUB_VV, OP_VAND_VV,
                             OP_VXOR_VV, OP_VADD_VX, OP_VMV_XS, OP_VREDSUM, OP_VREDSUM};

  `include "vec_ref_model.svh"

  vec_core #(.N(N), .NUM_LANES(NUM_LANES), .QUEUE_DEPTH(QUEUE_DEPTH)) vec_core_inst (.*);

  always #10 clk = ~clk;

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_xdata(input string what, input xaddr_t got_addr, input xdata_t got_data,
                             input xaddr_t exp_addr, input xdata_t exp_data);
    if (got_addr !== exp_addr || got_data !== exp_data) begin
      stop_run($sformatf("FAIL %0t: %s x%0d = %h, expected x%0d = %h", $time, what,
                         got_addr, got_data, exp_addr, exp_data));
    end
  endtask

  task automatic check_config(input config_state_t got, input config_state_t exp);
    if (got !== exp) begin
      stop_run($sformatf("FAIL %0t: config vl %0d, expected %0d", $time, got.vl, exp.vl));
    end
  endtask

  // Next edge then inputs after a small delay
  task automatic step();
    @(posedge clk);
    #1;
    async_rd_ready_i = rand_ready ? (($urandom % 4) == 0) : 1'b1;
  endtask

  task automatic enqueue_inst(input vec_op_e opc, input int vd, input int vs1, input int vs2,
                              input int rd, input xdata_t scalar);
    vec_inst_t ins;
    ins = '{op: opc, vd: vaddr_t'(vd), vs1: vaddr_t'(vs1), vs2: vaddr_t'(vs2),
            rd: xaddr_t'(rd)};
    prog_inst.push_back(ins);
    prog_scalar.push_back(scalar);
  endtask

  task automatic add_random(input int count);
    int pick;
    for (int k = 0; k < count; k++) begin
      pick = $urandom % 10;
      if (pick == 0) begin
        enqueue_inst(OP_VSETVL, 0, 0, 0, $urandom % 32, $urandom % 7);
      end else begin
        enqueue_inst(op_table[pick], $urandom % 8, $urandom % 8, $urandom % 8,
                     $urandom % 32, $urandom);
      end
    end
  endtask

  // Config write-back one cycle after a vsetvl and silent otherwise
  task automatic check_reg_writes();
    config_state_t cfg_exp;
    cfg_exp.vl = ref_vl;
    check_config(config_state_o, cfg_exp);
    for (int i = 0; i < N; i++) begin
      if (reg_write_valid_o[i] !== wr_exp_mask[i]) begin
        stop_run($sformatf("FAIL %0t: reg_write_valid_o[%0d] is %b, expected %b", $time, i,
                           reg_write_valid_o[i], wr_exp_mask[i]));
      end
      if (wr_exp_mask[i]) begin
        check_xdata("config write-back", reg_write_addr_o[i], reg_write_data_o[i],
                    wr_exp_addr[i], wr_exp_data[i]);
      end
    end
    wr_exp_mask = '0;
  endtask

  task automatic run_program();
    int     cycles;
    int     acc;
    xdata_t res;
    cycles = 0;
    while (prog_inst.size() > 0) begin
      for (int i = 0; i < N; i++) begin
        inst_valid_i[i] = (i < prog_inst.size());
        if (i < prog_inst.size()) begin
          inst_data_i[i] = prog_inst[i];
          reg_read_data_i[i] = prog_scalar[i];
        end else begin
          inst_data_i[i] = '0;
          reg_read_data_i[i] = '0;
        end
      end
      @(negedge clk);
      check_reg_writes();
      acc = 0;
      for (int i = 0; i < N; i++) begin
        if (inst_valid_i[i] && inst_ready_o[i]) begin
          if (acc != i) begin
            stop_run("a slot was accepted while a lower valid slot was not");
          end
          res = ref_execute(inst_data_i[i], reg_read_data_i[i]);
          acc++;
          if (inst_data_i[i].op == OP_VSETVL) begin
            wr_exp_mask[i] = 1'b1;
            wr_exp_addr[i] = inst_data_i[i].rd;
            wr_exp_data[i] = res;
          end else if (inst_data_i[i].op == OP_VMV_XS || inst_data_i[i].op == OP_VREDSUM) begin
            exp_addr_q.push_back(inst_data_i[i].rd);
            exp_data_q.push_back(res);
          end
        end
      end
      // Slots held back while the collector waits on the consumer
      if ((inst_valid_i & ~inst_ready_o) != '0 && async_rd_valid_o && !async_rd_ready_i) begin
        stall_seen = 1'b1;
      end
      step();
      repeat (acc) begin
        void'(prog_inst.pop_front());
        void'(prog_scalar.pop_front());
      end
      cycles++;
      if (cycles > RUN_TIMEOUT) begin
        stop_run("instruction slots stopped accepting the program");
      end
    end
    inst_valid_i = '0;
    @(negedge clk);
    check_reg_writes();
  endtask

  task automatic wait_idle();
    int cycles;
    cycles = 0;
    step();
    @(negedge clk);
    while (!idle_o) begin
      cycles++;
      if (cycles > IDLE_TIMEOUT) begin
        stop_run("idle_o did not return high after the burst");
      end
      step();
      @(negedge clk);
    end
    if (exp_addr_q.size() != 0) begin
      stop_run("core went idle with scalar results still missing");
    end
    step();
  endtask

  // Write-back compare with one expected result per handshake
  always @(negedge clk) begin
    if (held_valid) begin
      if (!async_rd_valid_o) begin
        stop_run("async write-back valid dropped without a handshake");
      end
      check_xdata("held write-back", async_rd_addr_o, async_rd_data_o, held_addr, held_data);
    end
    held_valid = 1'b0;
    if (async_rd_valid_o && async_rd_ready_i) begin
      if (exp_addr_q.size() == 0) begin
        stop_run("async write-back arrived with no result expected");
      end
      check_xdata("write-back", async_rd_addr_o, async_rd_data_o,
                  exp_addr_q.pop_front(), exp_data_q.pop_front());
    end else if (async_rd_valid_o) begin
      held_valid = 1'b1;
      held_addr = async_rd_addr_o;
      held_data = async_rd_data_o;
    end
  end

  initial begin
    void'($urandom(32'h6fea58ee));
    arst_n_i = 1'b0;
    inst_valid_i = '0;
    inst_data_i = '0;
    reg_read_data_i = '0;
    async_rd_ready_i = 1'b1;
    wr_exp_mask = '0;
    held_valid = 1'b0;
    rand_ready = 1'b0;
    stall_seen = 1'b0;
    repeat (2) @(posedge clk);
    #1;
    arst_n_i = 1'b1;
    @(negedge clk);
    if (!idle_o || async_rd_valid_o || reg_write_valid_o != '0 || inst_ready_o != '0) begin
      stop_run("outputs were not in their reset state");
    end
    check_config(config_state_o, '0);
    step();

    // avl above and below the lane count with several per cycle
    enqueue_inst(OP_VSETVL, 0, 0, 0, 1, 32'd9);
    enqueue_inst(OP_VSETVL, 0, 0, 0, 2, 32'd3);
    enqueue_inst(OP_VSETVL, 0, 0, 0, 3, 32'd0);
    enqueue_inst(OP_VSETVL, 0, 0, 0, 4, 32'd1);
    enqueue_inst(OP_VSETVL, 0, 0, 0, 5, 32'hffff_fff0);
    run_program();
    wait_idle();

    // Splat every register at full vl then run ops and readback
    for (int r = 0; r < NUM_VREGS; r++) begin
      enqueue_inst(OP_VMV_VX, r, 0, 0, 0, $urandom);
    end
    enqueue_inst(OP_VADD_VV, 1, 2, 3, 0, 0);
    enqueue_inst(OP_VSUB_VV, 4, 5, 1, 0, 0);
    enqueue_inst(OP_VAND_VV, 6, 7, 4, 0, 0);
    enqueue_inst(OP_VXOR_VV, 0, 6, 2, 0, 0);
    enqueue_inst(OP_VADD_VX, 3, 0, 0, 0, $urandom);
    for (int r = 0; r < NUM_VREGS; r++) begin
      enqueue_inst(OP_VMV_XS, 0, 0, r, 8 + r, 0);
      enqueue_inst(OP_VREDSUM, 0, 0, r, 16 + r, 0);
    end
    run_program();
    wait_idle();

    // Short vl with dependents in the same cycle and tails shown once vl rises
    enqueue_inst(OP_VSETVL, 0, 0, 0, 1, 32'd2);
    enqueue_inst(OP_VMV_VX, 5, 0, 0, 0, $urandom);
    enqueue_inst(OP_VADD_VV, 6, 5, 6, 0, 0);
    enqueue_inst(OP_VREDSUM, 0, 0, 6, 2, 0);
    enqueue_inst(OP_VSETVL, 0, 0, 0, 3, 32'd1);
    enqueue_inst(OP_VADD_VX, 5, 0, 5, 0, $urandom);
    enqueue_inst(OP_VREDSUM, 0, 0, 5, 4, 0);
    enqueue_inst(OP_VSETVL, 0, 0, 0, 5, 32'd4);
    enqueue_inst(OP_VREDSUM, 0, 0, 5, 6, 0);
    enqueue_inst(OP_VREDSUM, 0, 0, 6, 7, 0);
    enqueue_inst(OP_VMV_XS, 0, 0, 5, 8, 0);
    run_program();
    wait_idle();

    // Random program under random write-back back-pressure
    stall_seen = 1'b0;
    rand_ready = 1'b1;
    add_random(64);
    run_program();
    wait_idle();
    rand_ready = 1'b0;
    if (!stall_seen) begin
      stop_run("inst_ready_o never dropped under write-back back-pressure");
    end

    $display("sim passed");
    $finish;
  end

endmodule

//--- all.f
+incdir+test
src/vec_pkg.sv
src/vec_cmd_queue.sv
src/vec_frontend.sv
src/vec_dispatch.sv
src/vec_lane.sv
src/vec_result_collect.sv
src/vec_core.sv
test/vec_core_tb.sv
